// File: Makefile
# Verilator build and run of the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard rtl/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/lsu_checker.sv
//********************
// LSU checker
// Reference byte image, compares results and counts tests
//********************

`default_nettype none

module lsu_checker
    import lsu_pkg::*;
#(
    parameter int RETRY_LIMIT = 4
)
(
    input  wire           clk,
    input  wire           rst,
    input  wire mem_req_t req,
    input  wire           expect_err,
    input  wire           ack,
    input  wire           done,
    input  wire           err,
    input  wire word_t    load_data,
    input  wire wb_m2s_t  wb_out,
    input  wire wb_s2m_t  wb_in,
    output int            test_cnt,
    output int            fail_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] image [0:4095];
    mem_req_t   cur;
    logic       cur_expect_err;
    logic       busy;
    logic       bus_seen;
    logic       reset_pending;
    int         rty_cnt;
    int         req_idx;
    // Cycles since the ack of the current request
    int         lat;

    // Same start pattern as the memory
    function automatic logic [7:0] fill_byte(input int unsigned n);
        return 8'(n) ^ 8'(n >> 8) ^ 8'hA5;
    endfunction

    function automatic logic legal_funct3(input mem_req_t r);
        if (r.op == MEM_LOAD)
            return r.funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
        if (r.op == MEM_STORE)
            return r.funct3 inside {F3_B, F3_H, F3_W};
        return 1'b1;
    endfunction

    // Little-endian bytes from the image, then extended by funct3
    function automatic word_t expect_load(input mem_req_t r);
        word_t w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = image[12'(r.address) + 12'(i)];
        case (r.funct3)
            F3_B:    w = {{24{w[7]}}, w[7:0]};
            F3_BU:   w = {24'h0, w[7:0]};
            F3_H:    w = {{16{w[15]}}, w[15:0]};
            F3_HU:   w = {16'h0, w[15:0]};
            default: w = w;
        endcase
        return w;
    endfunction

    task automatic apply_store(input mem_req_t r);
        int nbytes;
        nbytes = (r.funct3 == F3_B) ? 1 : ((r.funct3 == F3_H) ? 2 : 4);
        for (int i = 0; i < nbytes; i++)
            image[12'(r.address) + 12'(i)] = r.store_data[8*i +: 8];
    endtask

    task automatic check_reset();
        test_cnt++;
        if (ack || done || err || wb_out.cyc || wb_out.stb || wb_out.we)
        begin
            $display("reset: a control output is high after reset");
            fail_cnt++;
        end
        else
            $display("reset: ok");
    endtask

    // Handshake pulse that belongs to no request in progress
    task automatic report_stray(input string name);
        test_cnt++;
        fail_cnt++;
        $display("unexpected %s pulse after request %0d", name, req_idx);
    endtask

    task automatic finish_request();
        logic  bad;
        word_t exp_data;
        bad = 1'b0;
        test_cnt++;
        if (done && err)
        begin
            $display("request %0d: done and err in the same cycle", req_idx);
            bad = 1'b1;
        end
        else if (err && !cur_expect_err)
        begin
            $display("request %0d: unexpected err", req_idx);
            bad = 1'b1;
        end
        else if (done && cur_expect_err)
        begin
            $display("request %0d: done where err was expected", req_idx);
            bad = 1'b1;
        end
        // No bus traffic for a none or an illegal request
        if (((cur.op == MEM_NONE) || !legal_funct3(cur)) && bus_seen)
        begin
            $display("request %0d: bus cycle on a request that needs none", req_idx);
            bad = 1'b1;
        end
        // None and illegal requests end two cycles after ack
        if (((cur.op == MEM_NONE) || !legal_funct3(cur)) && (lat != 2))
        begin
            $display("request %0d: finished %0d cycles after ack instead of 2",
                     req_idx, lat);
            bad = 1'b1;
        end
        if (err && wb_out.cyc)
        begin
            $display("request %0d: bus still active with err", req_idx);
            bad = 1'b1;
        end
        if (err && (cur.address[31:2] == 30'h100) && (rty_cnt != RETRY_LIMIT + 1))
        begin
            $display("ERR rty_count request %0d: expected %0h, got %0h",
                     req_idx, RETRY_LIMIT + 1, rty_cnt);
            bad = 1'b1;
        end
        if (done && (cur.op == MEM_LOAD))
        begin
            exp_data = expect_load(cur);
            if (load_data !== exp_data)
            begin
                $display("ERR load_data request %0d: expected %08h, got %08h",
                         req_idx, exp_data, load_data);
                bad = 1'b1;
            end
        end
        // Image only follows stores that completed
        if (done && (cur.op == MEM_STORE))
            apply_store(cur);
        if (bad)
            fail_cnt++;
        $display("request %0d %s f3=%0d at %08h: %s", req_idx, cur.op.name(),
                 cur.funct3, cur.address, bad ? "failed" : "ok");
        req_idx++;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int n = 0; n < 4096; n++)
                image[12'(n)] = fill_byte(n);
            busy          = 1'b0;
            bus_seen      = 1'b0;
            reset_pending = 1'b1;
            rty_cnt       = 0;
            req_idx       = 0;
            lat           = 0;
            test_cnt      = 0;
            fail_cnt      = 0;
        end
        else
        begin
            if (reset_pending)
            begin
                check_reset();
                reset_pending = 1'b0;
            end
            if (busy)
                lat++;
            // Request is still held on the ack cycle
            if (ack)
            begin
                // A long or second ack while a request runs
                if (busy)
                    report_stray("ack");
                cur            = req;
                cur_expect_err = expect_err;
                busy           = 1'b1;
                bus_seen       = 1'b0;
                rty_cnt        = 0;
                lat            = 0;
            end
            if (busy && wb_out.cyc)
                bus_seen = 1'b1;
            if (busy && wb_out.stb && wb_in.rty)
                rty_cnt++;
            if (busy && (done || err))
            begin
                finish_request();
                busy = 1'b0;
            end
            // Only one done or err per request
            else if (done || err)
                report_stray(done ? "done" : "err");
        end
    end

endmodule

`default_nettype wire

// File: dv/lsu_vectors.hex
// op funct3 address store_data expect_err, one request per line
// op: 0 none, 1 load, 2 store, f ends the list; expect_err: 1 err, 0 done
0 0 00000000 00000000 0
1 0 00000010 00000000 0
1 0 00000011 00000000 0
1 0 00000012 00000000 0
1 0 00000013 00000000 0
1 4 00000014 00000000 0
1 4 00000015 00000000 0
1 4 00000016 00000000 0
1 4 00000017 00000000 0
1 1 00000020 00000000 0
1 1 00000021 00000000 0
1 1 00000022 00000000 0
1 5 00000024 00000000 0
1 5 00000025 00000000 0
1 5 00000026 00000000 0
1 2 00000030 00000000 0
1 0 000000a1 00000000 0
1 1 000000a2 00000000 0
1 1 00000033 00000000 0
1 5 00000037 00000000 0
1 2 00000041 00000000 0
1 2 00000046 00000000 0
1 2 0000004b 00000000 0
2 0 00000051 000000c3 0
1 2 00000050 00000000 0
2 1 00000062 0000beef 0
1 2 00000060 00000000 0
2 1 00000073 00001234 0
1 2 00000070 00000000 0
1 2 00000074 00000000 0
2 2 00000085 cafef00d 0
1 2 00000084 00000000 0
1 2 00000088 00000000 0
2 2 00000090 89abcdef 0
1 2 00000090 00000000 0
1 2 00000400 00000000 1
2 0 00000401 00000055 1
1 2 00000fc0 00000000 1
1 2 00000fbd 00000000 1
1 3 00000010 00000000 1
2 4 00000020 00000011 1
1 2 00000030 00000000 0
f 0 00000000 00000000 0

// File: dv/tb_lsu.sv
//********************
// LSU testbench top
// Vector-driven requests into the LSU with a Wishbone memory
//********************

`default_nettype none

module tb_lsu
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RETRY_LIMIT = 4;
    localparam int MAX_VEC     = 100;
    localparam int WAIT_LIMIT  = 200;

    logic        clk;
    logic        rst;
    logic        cyc;
    mem_req_t    req;
    logic        expect_err;
    logic        ack;
    logic        done;
    logic        err;
    word_t       load_data;
    wb_m2s_t     wb_m2s;
    wb_s2m_t     wb_s2m;
    int          test_cnt;
    int          fail_cnt;
    logic        timed_out;

    // Five words per request: op, funct3, address, store data, expected err
    logic [31:0] vec_mem [0:511];

    lsu_top #(
        .RETRY_LIMIT (RETRY_LIMIT)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .req       (req),
        .ack       (ack),
        .done      (done),
        .err       (err),
        .load_data (load_data),
        .wb_out    (wb_m2s),
        .wb_in     (wb_s2m)
    );

    wb_mem_model u_mem (
        .clk (clk),
        .rst (rst),
        .m2s (wb_m2s),
        .s2m (wb_s2m)
    );

    lsu_checker #(
        .RETRY_LIMIT (RETRY_LIMIT)
    ) u_checker (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .expect_err (expect_err),
        .ack        (ack),
        .done       (done),
        .err        (err),
        .load_data  (load_data),
        .wb_out     (wb_m2s),
        .wb_in      (wb_s2m),
        .test_cnt   (test_cnt),
        .fail_cnt   (fail_cnt)
    );

    // 40 ns clock
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Drive one vector line, wait for ack and then for done or err
    task automatic run_request(input int idx, output logic ok);
        mem_req_t next_req;
        int       base;
        int       cnt;
        logic     seen;
        base = 5 * idx;
        next_req.op         = mem_op_t'(vec_mem[9'(base)][1:0]);
        next_req.funct3     = vec_mem[9'(base + 1)][2:0];
        next_req.address    = vec_mem[9'(base + 2)];
        next_req.store_data = vec_mem[9'(base + 3)];
        ok = 1'b1;
        req        <= next_req;
        expect_err <= vec_mem[9'(base + 4)][0];
        cyc        <= 1'b1;
        // Request stays up until the unit acknowledges it
        cnt  = 0;
        seen = 1'b0;
        while (!seen && (cnt < WAIT_LIMIT))
        begin
            @(posedge clk);
            seen = ack;
            cnt++;
        end
        cyc <= 1'b0;
        if (!seen)
        begin
            $display("request %0d: no ack within %0d cycles", idx, WAIT_LIMIT);
            ok = 1'b0;
        end
        else
        begin
            cnt  = 0;
            seen = 1'b0;
            while (!seen && (cnt < WAIT_LIMIT))
            begin
                @(posedge clk);
                seen = done || err;
                cnt++;
            end
            if (!seen)
            begin
                $display("request %0d: no done or err within %0d cycles", idx, WAIT_LIMIT);
                ok = 1'b0;
            end
        end
    endtask

    initial
    begin
        logic ok;
        rst        <= 1'b1;
        cyc        <= 1'b0;
        req        <= '0;
        expect_err <= 1'b0;
        timed_out = 1'b0;
        // Unused slots read as the end marker
        for (int i = 0; i < 512; i++)
            vec_mem[9'(i)] = 32'hF;
        $readmemh("dv/lsu_vectors.hex", vec_mem);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < MAX_VEC; n++)
        begin
            if (vec_mem[9'(5 * n)] == 32'hF)
                break;
            run_request(n, ok);
            if (!ok)
            begin
                timed_out = 1'b1;
                break;
            end
        end
        repeat (4) @(posedge clk);
        $display("%0d tests, %0d passed, %0d failed", test_cnt, test_cnt - fail_cnt, fail_cnt);
        if (timed_out || (fail_cnt != 0))
            $display("*** FAILED ***");
        else
            $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/wb_mem_model.sv
//********************
// Wishbone memory model
// 4 KB slave with random RTY, a busy block and an error block
//********************

`default_nettype none

module wb_mem_model
    import lsu_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire wb_m2s_t m2s,
    output wb_s2m_t      s2m
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam block_addr_t BUSY_BLOCK = 30'h100;
    localparam block_addr_t ERR_BLOCK  = 30'h3F0;

    logic [7:0]  mem [0:4095];
    logic [31:0] rng;
    int          rty_run;
    logic [11:0] base;
    logic        term;

    // Low byte of the address folded with its upper byte, then XOR A5
    function automatic logic [7:0] fill_byte(input int unsigned n);
        return 8'(n) ^ 8'(n >> 8) ^ 8'hA5;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign base = {m2s.adr[11:2], 2'b00};
    assign term = s2m.ack || s2m.err || s2m.rty;

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int n = 0; n < 4096; n++)
                mem[12'(n)] = fill_byte(n);
            rng     = 32'd72;
            rty_run = 0;
            s2m    <= '0;
        end
        else
        begin
            s2m.ack <= 1'b0;
            s2m.err <= 1'b0;
            s2m.rty <= 1'b0;
            // One registered answer per strobe, cleared when the master sees it
            if (m2s.cyc && m2s.stb && !term)
            begin
                rng = xorshift(rng);
                if (m2s.adr[31:2] == ERR_BLOCK)
                    s2m.err <= 1'b1;
                else if (m2s.adr[31:2] == BUSY_BLOCK)
                    s2m.rty <= 1'b1;
                // About one in four, never more than two in a row
                else if ((rng[1:0] == 2'b00) && (rty_run < 2))
                begin
                    s2m.rty <= 1'b1;
                    rty_run++;
                end
                else
                begin
                    rty_run = 0;
                    s2m.ack <= 1'b1;
                    if (m2s.we)
                    begin
                        for (int i = 0; i < 4; i++)
                            mem[base + 12'(i)] = m2s.dat[8*i +: 8];
                    end
                    s2m.dat <= {mem[base + 12'd3], mem[base + 12'd2],
                                mem[base + 12'd1], mem[base]};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_align_buffer.sv
//********************
// LSU alignment buffer
// 64-bit byte rotator with masked merge and load extension
//********************

`default_nettype none

module lsu_align_buffer
    import lsu_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire buf_cmd_t cmd,
    input  wire word_t    rd_data,
    input  wire decoded_t dec,
    output word_t         wr_data,
    output word_t         load_data
);

    // Bus side only sees the low half
    logic [63:0] rot_buf;
    byte_mask_t  mask;
    logic [7:0]  lo_byte;
    logic [15:0] lo_half;

    // Store width sets which low bytes get overwritten
    always_comb
    begin
        case (dec.size)
            SIZE_BYTE: mask = 4'b0001;
            SIZE_HALF: mask = 4'b0011;
            default:   mask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk)
    begin
        case (cmd)
            // Block reads land in the low half only
            BUF_CAPTURE:
                rot_buf[31:0] <= rd_data;
            // Right by one byte, byte 0 wraps to the top
            BUF_ROTATE:
                rot_buf <= {rot_buf[7:0], rot_buf[63:8]};
            BUF_MERGE:
                for (int i = 0; i < 4; i++)
                begin
                    if (mask[i])
                        rot_buf[8*i +: 8] <= dec.store_data[8*i +: 8];
                end
            default:
                rot_buf <= rot_buf;
        endcase
    end

    assign wr_data = rot_buf[31:0];

    assign lo_byte = rot_buf[7:0];
    assign lo_half = rot_buf[15:0];

    // Sign or zero extend the aligned data
    always_comb
    begin
        case (dec.size)
            SIZE_BYTE:
                load_data = {{24{dec.sign & lo_byte[7]}}, lo_byte};
            SIZE_HALF:
                load_data = {{16{dec.sign & lo_half[15]}}, lo_half};
            default:
                load_data = rot_buf[31:0];
        endcase
    end

    // Merge only ever follows a store request
    a_merge_store: assert property (@(posedge clk) disable iff (rst)
        (cmd == BUF_MERGE) |-> (dec.op == MEM_STORE));

endmodule

`default_nettype wire

// File: rtl/lsu_decode.sv
//********************
// LSU request decode
// Holds the accepted request, derives size and block info
//********************

`default_nettype none

module lsu_decode
    import lsu_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           accept,
    input  wire mem_req_t req,
    output decoded_t      dec
);

    mem_op_t      op_q;
    funct3_t      funct3_q;
    addr_t        addr_q;
    word_t        data_q;
    access_size_t size;
    logic         illegal;

    // Operation is control state, cleared on reset
    always_ff @(posedge clk)
    begin
        if (rst)
            op_q <= MEM_NONE;
        else if (accept)
            op_q <= req.op;
    end

    // Payload of the request
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            funct3_q <= req.funct3;
            addr_q   <= req.address;
            data_q   <= req.store_data;
        end
    end

    // Low two bits of funct3 give the width
    always_comb
    begin
        case (funct3_q[1:0])
            2'b00:   size = SIZE_BYTE;
            2'b01:   size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
    end

    // Stores have no unsigned forms
    always_comb
    begin
        case (op_q)
            MEM_NONE:  illegal = 1'b0;
            MEM_LOAD:  illegal = !(funct3_q inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
            MEM_STORE: illegal = !(funct3_q inside {F3_B, F3_H, F3_W});
            default:   illegal = 1'b1;
        endcase
    end

    always_comb
    begin
        dec.op         = op_q;
        dec.size       = size;
        dec.sign       = (funct3_q == F3_B) || (funct3_q == F3_H);
        dec.offset     = addr_q[1:0];
        dec.lo_block   = addr_q[31:2];
        // Next block up, holds the upper bytes of a crossing access
        dec.hi_block   = addr_q[31:2] + 30'd1;
        // Half at offset 3 or any word off zero spills into the next block
        dec.unaligned  = ((size == SIZE_HALF) && (addr_q[1:0] == 2'd3)) ||
                         ((size == SIZE_WORD) && (addr_q[1:0] != 2'd0));
        dec.illegal    = illegal;
        dec.store_data = data_q;
    end

    // Sequencer only accepts a defined operation
    a_accept_op: assert property (@(posedge clk) disable iff (rst)
        accept |-> !$isunknown(req.op) && (req.op inside {MEM_NONE, MEM_LOAD, MEM_STORE}));

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
//********************
// LSU package
// Widths, request, decode, buffer and Wishbone types
//********************

`default_nettype none

package lsu_pkg;

    // Address and data widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [29:0] block_addr_t;
    typedef logic [1:0]  byte_off_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [2:0]  funct3_t;

    // funct3 codes, shared by loads and stores
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} access_size_t;

    // Request from the control unit
    typedef struct packed {
        mem_op_t op;
        funct3_t funct3;
        addr_t   address;
        word_t   store_data;
    } mem_req_t;

    // Registered and decoded request
    typedef struct packed {
        mem_op_t      op;
        access_size_t size;
        logic         sign;
        byte_off_t    offset;
        block_addr_t  lo_block;
        block_addr_t  hi_block;
        logic         unaligned;
        logic         illegal;
        word_t        store_data;
    } decoded_t;

    typedef enum logic [1:0] {BUF_HOLD, BUF_CAPTURE, BUF_ROTATE, BUF_MERGE} buf_cmd_t;

    // Wishbone master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wb_m2s_t;

    // Wishbone slave to master
    typedef struct packed {
        logic  ack;
        logic  err;
        logic  rty;
        word_t dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

// File: rtl/lsu_sequencer.sv
//********************
// LSU sequencer
// Runs bus cycles, retries and rotations for each request
//********************

`default_nettype none

module lsu_sequencer
    import lsu_pkg::*;
#(
    parameter int RETRY_LIMIT = 4
)
(
    input  wire           clk,
    input  wire           rst,
    input  wire           cyc,
    input  wire decoded_t dec,
    output logic          accept,
    output logic          ack,
    output logic          done,
    output logic          err,
    output buf_cmd_t      buf_cmd,
    output wb_m2s_t       wb_out,
    input  wire wb_s2m_t  wb_in
);

    localparam int RTW = $clog2(RETRY_LIMIT + 2);

    // High block first when unaligned, then low block, align, store path
    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_READ_HI, ST_ROT_HI, ST_READ_LO, ST_ALIGN,
        ST_MERGE, ST_ROT_BACK, ST_WRITE_LO, ST_ROT_WR_HI, ST_WRITE_HI, ST_FINISH
    } state_t;

    state_t         state;
    logic [2:0]     rot_cnt;
    logic [RTW-1:0] retry_cnt;
    logic           holdoff;
    logic           bus_state;
    logic           bus_active;
    logic           retry_out;

    assign accept = (state == ST_IDLE) && cyc;

    assign bus_state = (state == ST_READ_HI) || (state == ST_READ_LO) ||
                       (state == ST_WRITE_LO) || (state == ST_WRITE_HI);
    // Drop the strobe for one cycle after a retry
    assign bus_active = bus_state && !holdoff;
    assign retry_out  = (retry_cnt == RTW'(RETRY_LIMIT));

    always_comb
    begin
        wb_out.cyc = bus_active;
        wb_out.stb = bus_active;
        wb_out.we  = bus_active && ((state == ST_WRITE_LO) || (state == ST_WRITE_HI));
        if ((state == ST_READ_HI) || (state == ST_WRITE_HI))
            wb_out.adr = {dec.hi_block, 2'b00};
        else
            wb_out.adr = {dec.lo_block, 2'b00};
        // Data lane is filled from the buffer at the top level
        wb_out.dat = '0;
    end

    always_comb
    begin
        buf_cmd = BUF_HOLD;
        case (state)
            ST_READ_HI, ST_READ_LO:
                if (bus_active && wb_in.ack)
                    buf_cmd = BUF_CAPTURE;
            ST_ROT_HI, ST_ALIGN, ST_ROT_BACK, ST_ROT_WR_HI:
                buf_cmd = BUF_ROTATE;
            ST_MERGE:
                buf_cmd = BUF_MERGE;
            default:
                buf_cmd = BUF_HOLD;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ST_IDLE;
            ack       <= 1'b0;
            done      <= 1'b0;
            err       <= 1'b0;
            holdoff   <= 1'b0;
            retry_cnt <= '0;
            rot_cnt   <= '0;
        end
        else
        begin
            ack     <= accept;
            done    <= 1'b0;
            err     <= 1'b0;
            holdoff <= 1'b0;
            // Retry count is per access
            if (!bus_state)
                retry_cnt <= '0;
            case (state)
                ST_IDLE:
                    if (accept)
                        state <= ST_START;
                // Decoded request is valid from here
                ST_START:
                    if (dec.illegal || (dec.op == MEM_NONE))
                        state <= ST_FINISH;
                    else if (dec.unaligned)
                        state <= ST_READ_HI;
                    else
                        state <= ST_READ_LO;
                ST_FINISH:
                begin
                    done  <= !dec.illegal;
                    err   <= dec.illegal;
                    state <= ST_IDLE;
                end
                ST_READ_HI, ST_READ_LO, ST_WRITE_LO, ST_WRITE_HI:
                begin
                    if (bus_active && wb_in.ack)
                    begin
                        case (state)
                            ST_READ_HI:
                            begin
                                // Four byte steps move the block to the high half
                                rot_cnt <= 3'd3;
                                state   <= ST_ROT_HI;
                            end
                            ST_READ_LO:
                                if (dec.offset != 2'd0)
                                begin
                                    rot_cnt <= {1'b0, dec.offset} - 3'd1;
                                    state   <= ST_ALIGN;
                                end
                                else if (dec.op == MEM_STORE)
                                    state <= ST_MERGE;
                                else
                                begin
                                    done  <= 1'b1;
                                    state <= ST_IDLE;
                                end
                            ST_WRITE_LO:
                                if (dec.unaligned)
                                begin
                                    rot_cnt <= 3'd3;
                                    state   <= ST_ROT_WR_HI;
                                end
                                else
                                begin
                                    done  <= 1'b1;
                                    state <= ST_IDLE;
                                end
                            default:
                            begin
                                done  <= 1'b1;
                                state <= ST_IDLE;
                            end
                        endcase
                    end
                    else if (bus_active && (wb_in.err || (wb_in.rty && retry_out)))
                    begin
                        err   <= 1'b1;
                        state <= ST_IDLE;
                    end
                    else if (bus_active && wb_in.rty)
                    begin
                        retry_cnt <= retry_cnt + 1'b1;
                        holdoff   <= 1'b1;
                    end
                end
                ST_ROT_HI:
                    if (rot_cnt == 3'd0)
                        state <= ST_READ_LO;
                    else
                        rot_cnt <= rot_cnt - 3'd1;
                ST_ALIGN:
                    if (rot_cnt != 3'd0)
                        rot_cnt <= rot_cnt - 3'd1;
                    else if (dec.op == MEM_STORE)
                        state <= ST_MERGE;
                    else
                    begin
                        // Last rotate lands with done, so load_data is ready
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                ST_MERGE:
                    if (dec.offset == 2'd0)
                        state <= ST_WRITE_LO;
                    else
                    begin
                        // Eight minus offset brings the bytes home
                        rot_cnt <= 3'd7 - {1'b0, dec.offset};
                        state   <= ST_ROT_BACK;
                    end
                ST_ROT_BACK:
                    if (rot_cnt == 3'd0)
                        state <= ST_WRITE_LO;
                    else
                        rot_cnt <= rot_cnt - 3'd1;
                ST_ROT_WR_HI:
                    if (rot_cnt == 3'd0)
                        state <= ST_WRITE_HI;
                    else
                        rot_cnt <= rot_cnt - 3'd1;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Strobe stays with cyc and a fixed address until terminated
    a_stb_held: assert property (@(posedge clk) disable iff (rst)
        wb_out.stb && !(wb_in.ack || wb_in.err || wb_in.rty)
        |=> wb_out.stb && wb_out.cyc && $stable(wb_out.adr));

    // Writes only happen for a store request
    a_we_store: assert property (@(posedge clk) disable iff (rst)
        wb_out.we |-> (dec.op == MEM_STORE));

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
//********************
// LSU top level
// Load/store unit with a Wishbone master port
//********************

`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int RETRY_LIMIT = 4
)
(
    input  wire           clk,
    input  wire           rst,

    // Request side
    input  wire           cyc,
    input  wire mem_req_t req,
    output logic          ack,
    output logic          done,
    output logic          err,
    output word_t         load_data,

    // Wishbone master
    output wb_m2s_t       wb_out,
    input  wire wb_s2m_t  wb_in
);

    logic     accept;
    decoded_t dec;
    buf_cmd_t buf_cmd;
    word_t    wr_data;
    wb_m2s_t  seq_bus;

    lsu_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .req    (req),
        .dec    (dec)
    );

    lsu_sequencer #(
        .RETRY_LIMIT (RETRY_LIMIT)
    ) u_sequencer (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .dec     (dec),
        .accept  (accept),
        .ack     (ack),
        .done    (done),
        .err     (err),
        .buf_cmd (buf_cmd),
        .wb_out  (seq_bus),
        .wb_in   (wb_in)
    );

    lsu_align_buffer u_align_buffer (
        .clk       (clk),
        .rst       (rst),
        .cmd       (buf_cmd),
        .rd_data   (wb_in.dat),
        .dec       (dec),
        .wr_data   (wr_data),
        .load_data (load_data)
    );

    // Control from the sequencer, write data from the buffer low half
    always_comb
    begin
        wb_out     = seq_bus;
        wb_out.dat = wr_data;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_sequencer.sv
rtl/lsu_align_buffer.sv
rtl/lsu_top.sv
dv/wb_mem_model.sv
dv/lsu_checker.sv
dv/tb_lsu.sv
